//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
TOP       := fetch_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F -- '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t fetch_pc_i,
    input  logic             bp_update_i,
    input  logic             bp_update_taken_i,
    input  fetch_pkg::addr_t bp_update_pc_i,
    input  fetch_pkg::addr_t bp_update_target_i,
    output logic             pred_hit_taken_o,
    output fetch_pkg::addr_t pred_target_o
);

    logic [fetch_pkg::BTB_ENTRIES-1:0] valid_q;
    logic [fetch_pkg::BTB_TAG_W-1:0]   tag_q    [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::ctr_t                   ctr_q    [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::addr_t                  target_q [fetch_pkg::BTB_ENTRIES];

    logic [fetch_pkg::BTB_IDX_W-1:0]   rd_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0]   rd_tag;
    logic [fetch_pkg::BTB_IDX_W-1:0]   wr_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0]   wr_tag;
    logic                              rd_hit;
    logic                              wr_hit;

    ////////////////////
    // Lookup
    ////////////////////

    // Tag sits right above the index bits
    assign rd_tag = fetch_pc_i[31 -: fetch_pkg::BTB_TAG_W];
    assign rd_idx = fetch_pc_i[31 - fetch_pkg::BTB_TAG_W -: fetch_pkg::BTB_IDX_W];
    assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    assign pred_hit_taken_o = rd_hit && ctr_q[rd_idx][1];
    assign pred_target_o    = target_q[rd_idx];

    ////////////////////
    // Training
    ////////////////////

    assign wr_tag = bp_update_pc_i[31 -: fetch_pkg::BTB_TAG_W];
    assign wr_idx = bp_update_pc_i[31 - fetch_pkg::BTB_TAG_W -: fetch_pkg::BTB_IDX_W];
    assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (bp_update_i && bp_update_taken_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bp_update_i) begin
            if (wr_hit) begin
                // Saturating counter step
                if (bp_update_taken_i && (ctr_q[wr_idx] != 2'b11)) begin
                    ctr_q[wr_idx] <= ctr_q[wr_idx] + 2'b01;
                end else if (!bp_update_taken_i && (ctr_q[wr_idx] != 2'b00)) begin
                    ctr_q[wr_idx] <= ctr_q[wr_idx] - 2'b01;
                end
            end else if (bp_update_taken_i) begin
                // New entry starts weakly taken
                tag_q[wr_idx] <= wr_tag;
                ctr_q[wr_idx] <= 2'b10;
            end
            if (bp_update_taken_i) begin
                target_q[wr_idx] <= bp_update_target_i;
            end
        end
    end

endmodule

//--- hw/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush_i,
    input  logic                 stall_i,
    input  logic                 pause_i,
    input  logic                 pred_hit_taken_i,
    output fetch_pkg::next_sel_e next_sel_o
);

    fetch_pkg::pause_state_e state_q;
    fetch_pkg::pause_state_e state_d;
    logic                    pause_hold;

    // Last step of the pause sequence is already done
    assign pause_hold = pause_i && (state_q != fetch_pkg::PAUSE_RUN);

    ////////////////////
    // Pause FSM
    ////////////////////

    always_comb begin
        state_d = state_q;
        if (flush_i) begin
            state_d = fetch_pkg::PAUSE_RUN;
        end else begin
            case (state_q)
                fetch_pkg::PAUSE_RUN: begin
                    if (pause_i) begin
                        state_d = fetch_pkg::PAUSE_STEP;
                    end
                end
                fetch_pkg::PAUSE_STEP: begin
                    state_d = pause_i ? fetch_pkg::PAUSE_HOLD : fetch_pkg::PAUSE_RUN;
                end
                fetch_pkg::PAUSE_HOLD: begin
                    if (!pause_i) begin
                        state_d = fetch_pkg::PAUSE_RUN;
                    end
                end
                default: begin
                    state_d = fetch_pkg::PAUSE_RUN;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= fetch_pkg::PAUSE_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////
    // Next-address priority
    ////////////////////

    always_comb begin
        if (flush_i) begin
            next_sel_o = fetch_pkg::SEL_REDIRECT;
        end else if (pause_hold || stall_i) begin
            next_sel_o = fetch_pkg::SEL_HOLD;
        end else if (pred_hit_taken_i) begin
            next_sel_o = fetch_pkg::SEL_PRED;
        end else begin
            next_sel_o = fetch_pkg::SEL_SEQ;
        end
    end

    a_redirect_iff_flush: assert property (@(posedge clk) disable iff (rst)
        (next_sel_o == fetch_pkg::SEL_REDIRECT) == flush_i);

endmodule

//--- hw/fetch_pkg.sv
package fetch_pkg;

    ////////////////////
    // Basic types
    ////////////////////

    typedef logic [31:0] addr_t;
    typedef logic [5:0]  exc_code_t;

    // Saturating branch counter, upper bit means taken
    typedef logic [1:0]  ctr_t;

    // Source of the next fetch address
    typedef enum logic [1:0] {
        SEL_HOLD     = 2'd0,
        SEL_SEQ      = 2'd1,
        SEL_PRED     = 2'd2,
        SEL_REDIRECT = 2'd3
    } next_sel_e;

    // Idle-wait sequence
    typedef enum logic [1:0] {
        PAUSE_RUN  = 2'd0,
        PAUSE_STEP = 2'd1,
        PAUSE_HOLD = 2'd2
    } pause_state_e;

    ////////////////////
    // Constants
    ////////////////////

    localparam addr_t     RESET_PC      = 32'h1c000000;
    localparam addr_t     BUNDLE_BYTES  = 32'd8;
    localparam addr_t     UNCACHE_LIMIT = 32'h1c000100;

    localparam exc_code_t EXC_NONE = 6'h00;
    localparam exc_code_t EXC_INT  = 6'h00;
    localparam exc_code_t EXC_ADEF = 6'h08;

    // BTB geometry, index from address bits 6:3
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;
    localparam int BTB_TAG_W   = 25;

endpackage

//--- hw/fetch_tag.sv
`timescale 1ns/1ps

module fetch_tag (
    input  logic                 clk,
    input  logic                 rst,
    input  fetch_pkg::addr_t     fetch_pc_i,
    input  logic                 interrupt_i,
    input  logic                 flush_i,
    output logic                 exc_valid_o,
    output fetch_pkg::exc_code_t exc_code_o,
    output logic                 uncache_o,
    output logic                 inst_en_o
);

    logic int_pending_q;
    logic misaligned;

    ////////////////////
    // Fetch exceptions
    ////////////////////

    // Interrupt stays pending until the back end flushes
    always_ff @(posedge clk) begin
        if (rst) begin
            int_pending_q <= 1'b0;
        end else if (flush_i) begin
            int_pending_q <= 1'b0;
        end else if (interrupt_i) begin
            int_pending_q <= 1'b1;
        end
    end

    assign misaligned  = |fetch_pc_i[1:0];
    assign exc_valid_o = int_pending_q || misaligned;

    always_comb begin
        if (int_pending_q) begin
            exc_code_o = fetch_pkg::EXC_INT;
        end else if (misaligned) begin
            exc_code_o = fetch_pkg::EXC_ADEF;
        end else begin
            exc_code_o = fetch_pkg::EXC_NONE;
        end
    end

    ////////////////////
    // Boot window decode
    ////////////////////

    assign uncache_o = (fetch_pc_i <= fetch_pkg::UNCACHE_LIMIT);
    assign inst_en_o = !uncache_o;

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush_i,
    input  logic                 stall_i,
    input  logic                 pause_i,
    input  logic                 interrupt_i,
    input  fetch_pkg::addr_t     new_pc_i,
    input  logic                 bp_update_i,
    input  logic                 bp_update_taken_i,
    input  fetch_pkg::addr_t     bp_update_pc_i,
    input  fetch_pkg::addr_t     bp_update_target_i,
    output fetch_pkg::addr_t     fetch_pc_o,
    output logic                 exc_valid_o,
    output fetch_pkg::exc_code_t exc_code_o,
    output logic                 uncache_o,
    output logic                 inst_en_o
);

    fetch_pkg::addr_t     fetch_pc;
    fetch_pkg::addr_t     pred_target;
    logic                 pred_hit_taken;
    fetch_pkg::next_sel_e next_sel;

    assign fetch_pc_o = fetch_pc;

    fetch_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .flush_i          (flush_i),
        .stall_i          (stall_i),
        .pause_i          (pause_i),
        .pred_hit_taken_i (pred_hit_taken),
        .next_sel_o       (next_sel)
    );

    pc_gen u_pc (
        .clk           (clk),
        .rst           (rst),
        .next_sel_i    (next_sel),
        .new_pc_i      (new_pc_i),
        .pred_target_i (pred_target),
        .fetch_pc_o    (fetch_pc)
    );

    branch_predictor u_bp (
        .clk                (clk),
        .rst                (rst),
        .fetch_pc_i         (fetch_pc),
        .bp_update_i        (bp_update_i),
        .bp_update_taken_i  (bp_update_taken_i),
        .bp_update_pc_i     (bp_update_pc_i),
        .bp_update_target_i (bp_update_target_i),
        .pred_hit_taken_o   (pred_hit_taken),
        .pred_target_o      (pred_target)
    );

    // Exception and cache attributes of the current fetch address
    fetch_tag u_tag (
        .clk         (clk),
        .rst         (rst),
        .fetch_pc_i  (fetch_pc),
        .interrupt_i (interrupt_i),
        .flush_i     (flush_i),
        .exc_valid_o (exc_valid_o),
        .exc_code_o  (exc_code_o),
        .uncache_o   (uncache_o),
        .inst_en_o   (inst_en_o)
    );

endmodule

//--- hw/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  fetch_pkg::next_sel_e next_sel_i,
    input  fetch_pkg::addr_t     new_pc_i,
    input  fetch_pkg::addr_t     pred_target_i,
    output fetch_pkg::addr_t     fetch_pc_o
);

    fetch_pkg::addr_t seq_pc;
    fetch_pkg::addr_t next_pc;

    // Next bundle, two instructions further
    assign seq_pc = fetch_pc_o + fetch_pkg::BUNDLE_BYTES;

    always_comb begin
        case (next_sel_i)
            fetch_pkg::SEL_REDIRECT: begin
                next_pc = new_pc_i;
            end
            fetch_pkg::SEL_PRED: begin
                next_pc = pred_target_i;
            end
            fetch_pkg::SEL_SEQ: begin
                next_pc = seq_pc;
            end
            default: begin
                next_pc = fetch_pc_o;
            end
        endcase
    end

    ////////////////////
    // PC register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc_o <= fetch_pkg::RESET_PC;
        end else begin
            fetch_pc_o <= next_pc;
        end
    end

    a_hold_keeps_pc: assert property (@(posedge clk) disable iff (rst)
        (next_sel_i == fetch_pkg::SEL_HOLD) |=> (fetch_pc_o == $past(fetch_pc_o)));

endmodule

//--- tb.f
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/pc_gen.sv
hw/branch_predictor.sv
hw/fetch_tag.sv
hw/fetch_top.sv
verif/fetch_tb.sv

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam fetch_pkg::addr_t TRAINED_PC     = 32'h1c001040;
    localparam fetch_pkg::addr_t TRAINED_TARGET = 32'h1c002000;
    localparam int               WAIT_LIMIT     = 40;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic                 stall;
    logic                 pause;
    logic                 interrupt;
    fetch_pkg::addr_t     new_pc;
    logic                 bp_update;
    logic                 bp_taken;
    fetch_pkg::addr_t     bp_pc;
    fetch_pkg::addr_t     bp_target;
    fetch_pkg::addr_t     fetch_pc;
    logic                 exc_valid;
    fetch_pkg::exc_code_t exc_code;
    logic                 uncache;
    logic                 inst_en;

    logic                 int_expected;
    logic                 trained;
    integer               seed;
    fetch_pkg::addr_t     rand_pc;

    fetch_top dut0 (
        .clk                (clk),
        .rst                (rst),
        .flush_i            (flush),
        .stall_i            (stall),
        .pause_i            (pause),
        .interrupt_i        (interrupt),
        .new_pc_i           (new_pc),
        .bp_update_i        (bp_update),
        .bp_update_taken_i  (bp_taken),
        .bp_update_pc_i     (bp_pc),
        .bp_update_target_i (bp_target),
        .fetch_pc_o         (fetch_pc),
        .exc_valid_o        (exc_valid),
        .exc_code_o         (exc_code),
        .uncache_o          (uncache),
        .inst_en_o          (inst_en)
    );

    always #50 clk = ~clk;

    // Pending interrupt as seen by the back end, flush wins
    always @(posedge clk) begin
        if (rst || flush) begin
            int_expected <= 1'b0;
        end else if (interrupt) begin
            int_expected <= 1'b1;
        end
    end

    function automatic fetch_pkg::exc_code_t expected_code(input logic pending,
                                                           input fetch_pkg::addr_t pc);
        return pending ? fetch_pkg::EXC_INT :
               ((pc[1:0] != 2'b00) ? fetch_pkg::EXC_ADEF : fetch_pkg::EXC_NONE);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic give_up(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    ////////////////////
    // Checks
    ////////////////////

    a_reset_pc: assert property (@(posedge clk) $fell(rst) |-> fetch_pc == fetch_pkg::RESET_PC)
        else report_mismatch("fetch_pc_o", $sampled(fetch_pc), fetch_pkg::RESET_PC);

    a_seq_step: assert property (@(posedge clk) disable iff (rst)
        (!flush && !stall && !pause && fetch_pc != TRAINED_PC)
            |=> fetch_pc == $past(fetch_pc) + fetch_pkg::BUNDLE_BYTES)
        else report_mismatch("fetch_pc_o", $sampled(fetch_pc),
                             $past(fetch_pc) + fetch_pkg::BUNDLE_BYTES);

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (stall && !flush) |=> fetch_pc == $past(fetch_pc))
        else report_mismatch("fetch_pc_o", $sampled(fetch_pc), $past(fetch_pc));

    a_redirect: assert property (@(posedge clk) disable iff (rst)
        flush |=> fetch_pc == $past(new_pc))
        else report_mismatch("fetch_pc_o", $sampled(fetch_pc), $past(new_pc));

    a_pred_taken: assert property (@(posedge clk) disable iff (rst)
        (trained && fetch_pc == TRAINED_PC && !flush && !stall && !pause)
            |=> fetch_pc == TRAINED_TARGET)
        else report_mismatch("fetch_pc_o", $sampled(fetch_pc), TRAINED_TARGET);

    // One last step when pause rises, then the PC stays put
    a_pause_step: assert property (@(posedge clk) disable iff (rst)
        ($rose(pause) && !stall && !flush && fetch_pc != TRAINED_PC)
            |=> fetch_pc == $past(fetch_pc) + fetch_pkg::BUNDLE_BYTES)
        else report_mismatch("fetch_pc_o", $sampled(fetch_pc),
                             $past(fetch_pc) + fetch_pkg::BUNDLE_BYTES);

    a_pause_hold: assert property (@(posedge clk) disable iff (rst)
        (pause && $past(pause) && !flush && !$past(flush)) |=> fetch_pc == $past(fetch_pc))
        else report_mismatch("fetch_pc_o", $sampled(fetch_pc), $past(fetch_pc));

    a_exc_valid: assert property (@(posedge clk) disable iff (rst)
        exc_valid == (int_expected || fetch_pc[1:0] != 2'b00))
        else report_mismatch("exc_valid_o", 32'($sampled(exc_valid)),
                             32'($sampled(int_expected) || $sampled(fetch_pc[1:0]) != 2'b00));

    a_exc_code: assert property (@(posedge clk) disable iff (rst)
        exc_code == expected_code(int_expected, fetch_pc))
        else report_mismatch("exc_code_o", 32'($sampled(exc_code)),
                             32'(expected_code($sampled(int_expected), $sampled(fetch_pc))));

    a_uncache: assert property (@(posedge clk) disable iff (rst)
        uncache == (fetch_pc <= fetch_pkg::UNCACHE_LIMIT))
        else report_mismatch("uncache_o", 32'($sampled(uncache)),
                             32'($sampled(fetch_pc) <= fetch_pkg::UNCACHE_LIMIT));

    a_inst_en: assert property (@(posedge clk) disable iff (rst)
        inst_en == (fetch_pc > fetch_pkg::UNCACHE_LIMIT))
        else report_mismatch("inst_en_o", 32'($sampled(inst_en)),
                             32'($sampled(fetch_pc) > fetch_pkg::UNCACHE_LIMIT));

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic wait_for_pc(input fetch_pkg::addr_t pc, input string what);
        int cycles;
        cycles = 0;
        while (fetch_pc !== pc) begin
            if (cycles == WAIT_LIMIT) begin
                give_up(what);
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_for_exc(input logic valid, input string what);
        int cycles;
        cycles = 0;
        while (exc_valid !== valid || exc_code !== fetch_pkg::EXC_INT) begin
            if (cycles == WAIT_LIMIT) begin
                give_up(what);
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic redirect(input fetch_pkg::addr_t pc);
        new_pc = pc;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        wait_for_pc(pc, "redirect target never reached fetch_pc_o");
    endtask

    initial begin
        seed = 32'h16a7_68ab;
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        pause = 1'b0;
        interrupt = 1'b0;
        new_pc = '0;
        bp_update = 1'b0;
        bp_taken = 1'b0;
        bp_pc = '0;
        bp_target = '0;
        trained = 1'b0;
        // Bundle aligned, and never the trained branch
        rand_pc = TRAINED_PC;
        while (rand_pc[31:3] == TRAINED_PC[31:3]) begin
            rand_pc = {$random(seed)} & 32'hffff_fff8;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (4) @(negedge clk);
        stall = 1'b1;
        repeat (3) @(negedge clk);
        stall = 1'b0;
        repeat (2) @(negedge clk);

        // Misaligned target above the boot window, then an interrupt on top
        redirect(32'h1c000102);
        interrupt = 1'b1;
        wait_for_exc(1'b1, "held interrupt never raised the fetch exception");
        repeat (2) @(negedge clk);
        interrupt = 1'b0;
        redirect(32'h1c001000);
        wait_for_exc(1'b0, "flush did not clear the pending interrupt");

        // Two taken updates, one not taken elsewhere
        bp_update = 1'b1;
        bp_taken = 1'b1;
        bp_pc = TRAINED_PC;
        bp_target = TRAINED_TARGET;
        repeat (2) @(negedge clk);
        bp_taken = 1'b0;
        bp_pc = rand_pc;
        @(negedge clk);
        bp_update = 1'b0;
        trained = 1'b1;
        redirect(TRAINED_PC - 32'd16);
        wait_for_pc(TRAINED_TARGET, "trained branch target was never fetched");

        pause = 1'b1;
        repeat (4) @(negedge clk);
        pause = 1'b0;
        repeat (3) @(negedge clk);

        redirect(rand_pc);
        repeat (4) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule
